//--- sdcard_pkg.sv
package sdcard_pkg;

    // CMD8 argument view
    typedef struct packed {
        logic [17:0] reserved;
        logic        pcie_1v2;
        logic        pcie_avail;
        logic [3:0]  vhs;          // Voltage supplied
        logic [7:0]  check;        // Echo pattern
    } sd_if_cond_t;

    // ACMD41 argument and OCR view
    typedef struct packed {
        logic        busy;         // Power-up done in OCR
        logic        hcs;
        logic [5:0]  reserved;
        logic [23:0] vdd_window;
    } sd_op_cond_t;

    typedef union packed {
        sd_if_cond_t if_cond;
        sd_op_cond_t op_cond;
        logic [31:0] blk_addr;     // CMD17 block number
    } sd_arg_u;

    typedef struct packed {
        logic [5:0] index;
        sd_arg_u    arg;
        logic       crc_ok;        // Start, CRC7 and end bit all good
    } sd_cmd_t;

    typedef enum logic [1:0] {
        RESP_R1,
        RESP_R3,
        RESP_R7
    } sd_resp_kind_e;

    typedef struct packed {
        sd_resp_kind_e kind;
        logic [7:0]    r1;
        logic [31:0]   payload;    // OCR or interface condition
        logic          start_data; // Read block follows
    } sd_resp_t;

    localparam int R1_IN_IDLE        = 0;
    localparam int R1_ILLEGAL_CMD    = 2;
    localparam int R1_COM_CRC_ERROR  = 3;

    localparam logic [5:0] CMD_GO_IDLE         = 6'd0;
    localparam logic [5:0] CMD_SEND_IF_COND    = 6'd8;
    localparam logic [5:0] CMD_READ_SINGLE     = 6'd17;
    localparam logic [5:0] CMD_SD_SEND_OP_COND = 6'd41;
    localparam logic [5:0] CMD_APP_CMD         = 6'd55;
    localparam logic [5:0] CMD_READ_OCR        = 6'd58;

    localparam logic [7:0] DATA_TOKEN = 8'hFE;

endpackage

//--- sdcard_crc16.sv
`timescale 1ns/1ps

module sdcard_crc16 (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_clear,
    input  logic        i_next,
    input  logic [7:0]  i_byte,
    output logic [15:0] o_crc
);

    logic [15:0] crc_q;
    logic [15:0] crc_n;

    // CCITT 0x1021, one byte MSB first
    always_comb begin
        logic fb;
        crc_n = crc_q;
        for (int i = 7; i >= 0; i--) begin
            fb    = crc_n[15] ^ i_byte[i];
            crc_n = {crc_n[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= crc_n;
        end
    end

    assign o_crc = crc_q;

endmodule

//--- sdcard_mem.sv
`timescale 1ns/1ps

module sdcard_mem #(
    parameter int P_MEM_BYTES = 64
) (
    input  logic                           i_clk,
    input  logic [$clog2(P_MEM_BYTES)-1:0] i_addr,
    output logic [7:0]                     o_rdata
);

    logic [7:0] mem [P_MEM_BYTES];

    // Image of the card contents
    initial begin
        $readmemh("sdcard_mem.hex", mem);
    end

    always_ff @(posedge i_clk) begin
        o_rdata <= mem[i_addr];             // One cycle read latency
    end

endmodule

//--- sdcard_cmd_rx.sv
`timescale 1ns/1ps

module sdcard_cmd_rx (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_cs,
    input  logic               i_mosi,
    output logic               o_cmd_valid,
    output sdcard_pkg::sd_cmd_t o_cmd
);

    logic        active;           // Frame in progress
    logic [5:0]  bit_cnt;
    logic [46:0] shift_q;
    logic [6:0]  crc7_q;
    logic [47:0] frame_n;
    logic [6:0]  crc7_base;
    logic [6:0]  crc7_n;
    logic        crc7_fb;
    logic        take_bit;
    logic        last_bit;

    assign frame_n  = {shift_q, i_mosi};
    assign take_bit = !i_cs && (active || !i_mosi);
    assign last_bit = active && !i_cs && (bit_cnt == 6'd47);

    // CRC7, x^7 + x^3 + 1, restarted on the start bit
    always_comb begin
        crc7_base = active ? crc7_q : 7'd0;
        crc7_fb   = crc7_base[6] ^ i_mosi;
        crc7_n    = {crc7_base[5:0], 1'b0} ^ (crc7_fb ? 7'h09 : 7'h00);
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            active      <= 1'b0;
            bit_cnt     <= '0;
            o_cmd_valid <= 1'b0;
        end else begin
            o_cmd_valid <= 1'b0;
            if (i_cs) begin
                active <= 1'b0;                 // Partial frame dropped
            end else if (!active) begin
                if (!i_mosi) begin
                    active  <= 1'b1;
                    bit_cnt <= 6'd1;
                end
            end else begin
                bit_cnt <= bit_cnt + 6'd1;
                if (last_bit) begin
                    active      <= 1'b0;
                    o_cmd_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_bit) begin
            shift_q <= frame_n[46:0];
            if (!active || bit_cnt < 6'd40) begin
                crc7_q <= crc7_n;               // Only over index and argument
            end
        end
        if (last_bit) begin
            o_cmd.index        <= frame_n[45:40];
            o_cmd.arg.blk_addr <= frame_n[39:8];
            o_cmd.crc_ok       <= frame_n[46] && (frame_n[7:1] == crc7_q) && frame_n[0];
        end
    end

endmodule

//--- sdcard_resp_tx.sv
`timescale 1ns/1ps

module sdcard_resp_tx #(
    parameter int P_NCR_BYTES = 1
) (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic                 i_resp_valid,
    input  sdcard_pkg::sd_resp_t i_resp,
    input  logic                 i_dat_trans,
    input  logic                 i_dat_bit,
    output logic                 o_tx_busy,
    output logic                 o_miso
);

    logic [2:0]  bit_cnt;
    logic [3:0]  byte_cnt;         // Counts filler bytes too
    logic [3:0]  last_byte;
    logic [47:0] shift_q;
    logic        in_ncr;

    assign in_ncr = byte_cnt < 4'(P_NCR_BYTES);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_tx_busy <= 1'b0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
        end else if (i_resp_valid) begin
            o_tx_busy <= 1'b1;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
        end else if (o_tx_busy) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                byte_cnt <= byte_cnt + 4'd1;
                if (byte_cnt == last_byte) o_tx_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_resp_valid) begin
            shift_q   <= {i_resp.r1, i_resp.payload, 8'hFF};
            // R1 alone or R1 plus four payload bytes
            last_byte <= 4'(P_NCR_BYTES) +
                         ((i_resp.kind == sdcard_pkg::RESP_R1) ? 4'd0 : 4'd4);
        end else if (o_tx_busy && !in_ncr) begin
            shift_q <= {shift_q[46:0], 1'b1};
        end
    end

    always_comb begin
        if (o_tx_busy) o_miso = in_ncr ? 1'b1 : shift_q[47];
        else if (i_dat_trans) o_miso = i_dat_bit;
        else o_miso = 1'b1;                 // Bus idles high
    end

    a_no_resp_while_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resp_valid |-> !o_tx_busy)
        else $error("new response while previous one is still shifting");

    // Block sequencer must hold off until the response is out
    a_no_block_overlap: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_tx_busy |-> !i_dat_trans)
        else $error("data block overlaps a response");

endmodule

//--- sdcard_ctrl.sv
`timescale 1ns/1ps

module sdcard_ctrl #(
    parameter int          P_POWERUP_CYCLES = 450,
    parameter int          P_BLOCK_BYTES    = 512,
    parameter int          P_MEM_BYTES      = 64,
    parameter logic [3:0]  P_VHS            = 4'h1,
    parameter logic [23:0] P_VDD_WINDOW     = 24'hFF8000,
    parameter logic        P_HCS            = 1'b1
) (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_cmd_valid,
    input  sdcard_pkg::sd_cmd_t             i_cmd,
    input  logic                           i_tx_busy,
    input  logic                           i_cs,
    output logic                           o_resp_valid,
    output sdcard_pkg::sd_resp_t            o_resp,
    output logic [$clog2(P_MEM_BYTES)-1:0] o_mem_addr,
    input  logic [7:0]                     i_mem_rdata,
    output logic                           o_crc16_clear,
    output logic                           o_crc16_next,
    output logic [7:0]                     o_crc_byte,
    input  logic [15:0]                    i_crc16,
    output logic                           o_dat_trans,
    output logic                           o_dat_bit
);

    localparam int AW = $clog2(P_MEM_BYTES);
    localparam int BW = $clog2(P_BLOCK_BYTES);
    localparam int PW = $clog2(P_POWERUP_CYCLES + 1);

    localparam logic [1:0] SEQ_IDLE  = 2'd0;
    localparam logic [1:0] SEQ_TOKEN = 2'd1;
    localparam logic [1:0] SEQ_DATA  = 2'd2;
    localparam logic [1:0] SEQ_CRC   = 2'd3;

    logic                 card_ready;    // 0 is the idle state
    logic [PW-1:0]        pwr_cnt;
    logic                 pwr_done;
    logic                 ocr_hcs;
    logic [23:0]          ocr_window;
    logic                 rd_pending;
    logic [1:0]           seq;
    logic [3:0]           bit_cnt;
    logic [BW-1:0]        byte_cnt;
    logic [15:0]          dat_sh;
    sdcard_pkg::sd_resp_t resp_n;
    sdcard_pkg::sd_arg_u  pl;
    logic                 ready_n;
    logic                 ocr_latch;
    logic [31:0]          blk_byte;
    logic                 byte_end;
    logic                 last_byte;
    logic                 mem_step;

    always_comb begin
        resp_n      = '0;
        pl          = '0;
        ready_n     = card_ready;
        ocr_latch   = 1'b0;
        blk_byte    = i_cmd.arg.blk_addr * 32'(P_BLOCK_BYTES);
        resp_n.kind = sdcard_pkg::RESP_R1;
        resp_n.r1[sdcard_pkg::R1_IN_IDLE] = !card_ready;
        if (!i_cmd.crc_ok) begin
            resp_n.r1[sdcard_pkg::R1_COM_CRC_ERROR] = 1'b1;
        end else begin
            case (i_cmd.index)
                sdcard_pkg::CMD_GO_IDLE: begin
                    resp_n.r1 = 8'h01;
                    ready_n   = 1'b0;
                end
                sdcard_pkg::CMD_SEND_IF_COND: begin
                    resp_n.kind      = sdcard_pkg::RESP_R7;
                    pl.if_cond.vhs   = i_cmd.arg.if_cond.vhs & P_VHS;
                    pl.if_cond.check = i_cmd.arg.if_cond.check;
                end
                sdcard_pkg::CMD_APP_CMD: begin
                end
                sdcard_pkg::CMD_SD_SEND_OP_COND: begin
                    if ((i_cmd.arg.op_cond.vdd_window & P_VDD_WINDOW) == 24'd0) begin
                        resp_n.r1[sdcard_pkg::R1_ILLEGAL_CMD] = 1'b1;
                    end else begin
                        ocr_latch = 1'b1;
                        ready_n   = pwr_done;   // Still busy until power-up ends
                        resp_n.r1 = {7'd0, !pwr_done};
                    end
                end
                sdcard_pkg::CMD_READ_OCR: begin
                    resp_n.kind           = sdcard_pkg::RESP_R3;
                    pl.op_cond.busy       = pwr_done;
                    pl.op_cond.hcs        = ocr_hcs & P_HCS;
                    pl.op_cond.vdd_window = ocr_window & P_VDD_WINDOW;
                end
                sdcard_pkg::CMD_READ_SINGLE: begin
                    if (card_ready) begin
                        resp_n.start_data = 1'b1;
                    end else begin
                        resp_n.r1[sdcard_pkg::R1_ILLEGAL_CMD] = 1'b1;
                    end
                end
                default: resp_n.r1[sdcard_pkg::R1_ILLEGAL_CMD] = 1'b1;
            endcase
        end
        resp_n.payload = pl;
    end

    assign byte_end      = bit_cnt[2:0] == 3'd7;
    assign last_byte     = byte_cnt == BW'(P_BLOCK_BYTES - 1);
    assign mem_step      = byte_end && (seq == SEQ_TOKEN || (seq == SEQ_DATA && !last_byte));
    assign o_crc16_clear = seq == SEQ_IDLE;
    assign o_crc16_next  = mem_step;       // Byte is sampled as it enters the shifter
    assign o_crc_byte    = i_mem_rdata;
    assign o_dat_bit     = dat_sh[15];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            card_ready   <= 1'b0;
            pwr_cnt      <= '0;
            pwr_done     <= 1'b0;
            ocr_hcs      <= 1'b0;
            ocr_window   <= '0;
            o_resp_valid <= 1'b0;
            rd_pending   <= 1'b0;
            seq          <= SEQ_IDLE;
            bit_cnt      <= '0;
            byte_cnt     <= '0;
            o_dat_trans  <= 1'b0;
        end else begin
            if (!pwr_done) begin
                if (pwr_cnt == PW'(P_POWERUP_CYCLES)) pwr_done <= 1'b1;
                else pwr_cnt <= pwr_cnt + 1'b1;
            end
            o_resp_valid <= i_cmd_valid;
            if (i_cmd_valid) begin
                card_ready <= ready_n;
                if (ocr_latch) begin
                    ocr_hcs    <= i_cmd.arg.op_cond.hcs;
                    ocr_window <= i_cmd.arg.op_cond.vdd_window;
                end
            end
            if (o_resp_valid && o_resp.start_data) rd_pending <= 1'b1;
            case (seq)
                SEQ_IDLE: begin
                    if (rd_pending && !i_tx_busy && !i_cs) begin
                        seq         <= SEQ_TOKEN;
                        rd_pending  <= 1'b0;
                        bit_cnt     <= '0;
                        byte_cnt    <= '0;
                        o_dat_trans <= 1'b1;
                    end
                end
                SEQ_TOKEN, SEQ_DATA: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (byte_end) begin
                        bit_cnt <= '0;
                        if (seq == SEQ_TOKEN) seq <= SEQ_DATA;
                        else byte_cnt <= byte_cnt + 1'b1;
                        if (seq == SEQ_DATA && last_byte) seq <= SEQ_CRC;
                    end
                end
                default: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd15) begin
                        seq         <= SEQ_IDLE;
                        o_dat_trans <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd_valid) o_resp <= resp_n;
        if (i_cmd_valid && resp_n.start_data) o_mem_addr <= blk_byte[AW-1:0];
        else if (mem_step) o_mem_addr <= o_mem_addr + 1'b1;
        if (seq == SEQ_IDLE) dat_sh <= {sdcard_pkg::DATA_TOKEN, 8'hFF};
        else if (mem_step) dat_sh <= {i_mem_rdata, 8'hFF};
        else if (seq == SEQ_DATA && byte_end) dat_sh <= i_crc16;
        else dat_sh <= {dat_sh[14:0], 1'b1};
    end

    // Host waits for the whole response before the next frame
    a_no_cmd_while_tx: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_cmd_valid |-> !i_tx_busy)
        else $error("command strobe while response transmitter is busy");

endmodule

//--- sdcard_spi_top.sv
`timescale 1ns/1ps

module sdcard_spi_top #(
    parameter int          P_POWERUP_CYCLES = 450,
    parameter int          P_NCR_BYTES      = 1,
    parameter int          P_BLOCK_BYTES    = 512,
    parameter int          P_MEM_BYTES      = 64,
    parameter logic [3:0]  P_VHS            = 4'h1,
    parameter logic [23:0] P_VDD_WINDOW     = 24'hFF8000,
    parameter logic        P_HCS            = 1'b1
) (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_cs,
    input  logic i_mosi,
    output logic o_miso
);

    localparam int AW = $clog2(P_MEM_BYTES);

    sdcard_pkg::sd_cmd_t  cmd;
    sdcard_pkg::sd_resp_t resp;
    logic                 cmd_valid;
    logic                 resp_valid;
    logic                 tx_busy;
    logic [AW-1:0]        mem_addr;
    logic [7:0]           mem_rdata;
    logic                 crc16_clear;
    logic                 crc16_next;
    logic [7:0]           crc_byte;
    logic [15:0]          crc16;
    logic                 dat_trans;
    logic                 dat_bit;

    sdcard_cmd_rx i_cmd_rx (
        .i_clk, .i_nrst, .i_cs, .i_mosi,
        .o_cmd_valid(cmd_valid), .o_cmd(cmd)
    );

    sdcard_ctrl #(
        .P_POWERUP_CYCLES(P_POWERUP_CYCLES), .P_BLOCK_BYTES(P_BLOCK_BYTES),
        .P_MEM_BYTES(P_MEM_BYTES), .P_VHS(P_VHS),
        .P_VDD_WINDOW(P_VDD_WINDOW), .P_HCS(P_HCS)
    ) i_ctrl (
        .i_clk, .i_nrst, .i_cmd_valid(cmd_valid), .i_cmd(cmd),
        .i_tx_busy(tx_busy), .i_cs,
        .o_resp_valid(resp_valid), .o_resp(resp),
        .o_mem_addr(mem_addr), .i_mem_rdata(mem_rdata),
        .o_crc16_clear(crc16_clear), .o_crc16_next(crc16_next),
        .o_crc_byte(crc_byte), .i_crc16(crc16),
        .o_dat_trans(dat_trans), .o_dat_bit(dat_bit)
    );

    sdcard_resp_tx #(.P_NCR_BYTES(P_NCR_BYTES)) i_resp_tx (
        .i_clk, .i_nrst, .i_resp_valid(resp_valid), .i_resp(resp),
        .i_dat_trans(dat_trans), .i_dat_bit(dat_bit),
        .o_tx_busy(tx_busy), .o_miso
    );

    sdcard_mem #(.P_MEM_BYTES(P_MEM_BYTES)) i_mem (
        .i_clk, .i_addr(mem_addr), .o_rdata(mem_rdata)
    );

    sdcard_crc16 i_crc16 (
        .i_clk, .i_nrst, .i_clear(crc16_clear), .i_next(crc16_next),
        .i_byte(crc_byte), .o_crc(crc16)
    );

endmodule

//--- tb_sdcard_checker.sv
`timescale 1ns/1ps

module tb_sdcard_checker #(
    parameter int P_BLOCK_BYTES = 16,
    parameter int P_MEM_BYTES   = 64
) (
    input  logic                      i_clk,
    input  logic                      i_cs,
    input  logic                      i_miso,
    input  logic                      i_start,
    input  logic [127:0]              i_name,
    input  sdcard_pkg::sd_resp_kind_e i_kind,
    input  logic [7:0]                i_r1,
    input  logic [31:0]               i_payload,
    input  logic                      i_block,
    input  int                        i_blk_start,
    output logic                      o_done,
    output int                        o_errors
);

    // Host takes MISO on the rising edge while selected
    task automatic get_bit(output logic b);
        @(posedge i_clk);
        while (i_cs) @(posedge i_clk);
        b = i_miso;
    endtask

    task automatic get_byte(output logic [7:0] v);
        logic b;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            get_bit(b);
            v = {v[6:0], b};
        end
    endtask

    // Skips idle ones up to and including the first 0
    task automatic hunt_zero();
        logic b;
        b = 1'b1;
        while (b) begin
            get_bit(b);
        end
    endtask

    // CCITT x^16 + x^12 + x^5 + 1 taken MSB first
    function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] d);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[15] ^ d[i];
            c  = {c[14:12], c[11] ^ fb, c[10:5], c[4] ^ fb, c[3:0], fb};
        end
        return c;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            o_errors++;
            $display("** Error %0s %0s: expected %0h, got %0h", i_name, what, exp, act);
        end
    endtask

    task automatic check_response();
        logic [7:0]  r1;
        logic [7:0]  data;
        logic [7:0]  exp_byte;
        logic [31:0] payload;
        logic [15:0] crc_exp;
        logic [15:0] crc_act;
        logic        b;
        int          addr;
        hunt_zero();                        // Zero is the r1 MSB
        r1 = '0;
        for (int i = 0; i < 7; i++) begin
            get_bit(b);
            r1 = {r1[6:0], b};
        end
        compare("r1", 32'(i_r1), 32'(r1));
        payload = '0;
        if (i_kind != sdcard_pkg::RESP_R1) begin
            for (int i = 0; i < 4; i++) begin
                get_byte(data);
                payload = {payload[23:0], data};
            end
            compare("payload", i_payload, payload);
        end
        if (i_block && r1 == 8'h00) begin
            hunt_zero();                    // Token ends in its only 0 bit
            crc_exp = '0;
            for (int i = 0; i < P_BLOCK_BYTES; i++) begin
                addr     = (i_blk_start + i) % P_MEM_BYTES;
                exp_byte = 8'((3 * addr + 1) % 256);
                get_byte(data);
                compare($sformatf("data[%0d]", i), 32'(exp_byte), 32'(data));
                crc_exp = crc16_step(crc_exp, exp_byte);
            end
            get_byte(data);
            crc_act[15:8] = data;
            get_byte(data);
            crc_act[7:0] = data;
            compare("crc16", 32'(crc_exp), 32'(crc_act));
        end else if (i_block) begin
            o_errors++;
            $display("Test %0s: card did not accept the read, no data block to check", i_name);
        end
    endtask

    initial begin
        o_done   = 1'b0;
        o_errors = 0;
        forever begin
            @(posedge i_clk);
            o_done = 1'b0;
            if (i_start) begin
                check_response();
                o_done = 1'b1;              // Held for one cycle
            end
        end
    end

endmodule

//--- tb_sdcard.sv
`timescale 1ns/1ps

module tb_sdcard;

    localparam int P_POWERUP_CYCLES = 300;
    localparam int P_NCR_BYTES      = 1;
    localparam int P_BLOCK_BYTES    = 16;
    localparam int P_MEM_BYTES      = 64;
    localparam int N_TESTS          = 13;
    // Worst case per test is a frame plus response and block, doubled for slack
    localparam int MAX_CYCLES = N_TESTS * (48 + 8 * (P_NCR_BYTES + 4 + P_BLOCK_BYTES + 3)) * 2
                                + P_POWERUP_CYCLES;

    localparam sdcard_pkg::sd_resp_kind_e K_R1 = sdcard_pkg::RESP_R1;
    localparam sdcard_pkg::sd_resp_kind_e K_R3 = sdcard_pkg::RESP_R3;
    localparam sdcard_pkg::sd_resp_kind_e K_R7 = sdcard_pkg::RESP_R7;

    typedef struct packed {
        logic [127:0]              name;
        logic [5:0]                index;
        logic [31:0]               arg;
        logic                      bad_crc;
        sdcard_pkg::sd_resp_kind_e kind;
        logic [7:0]                r1;
        logic [31:0]               payload;
        logic                      block;     // Read block expected after r1
    } test_t;

    logic  i_clk;
    logic  i_nrst;
    logic  i_cs;
    logic  i_mosi;
    logic  o_miso;
    logic  start;
    logic  done;
    int    errors;
    int    cycles;
    int    test_no;
    int    blk_start;
    test_t cur;
    test_t tests [N_TESTS];

    sdcard_spi_top #(
        .P_POWERUP_CYCLES(P_POWERUP_CYCLES), .P_NCR_BYTES(P_NCR_BYTES),
        .P_BLOCK_BYTES(P_BLOCK_BYTES), .P_MEM_BYTES(P_MEM_BYTES)
    ) i_sdcard_spi_top (
        .i_clk, .i_nrst, .i_cs, .i_mosi, .o_miso
    );

    tb_sdcard_checker #(
        .P_BLOCK_BYTES(P_BLOCK_BYTES), .P_MEM_BYTES(P_MEM_BYTES)
    ) i_checker (
        .i_clk, .i_cs, .i_miso(o_miso), .i_start(start),
        .i_name(cur.name), .i_kind(cur.kind), .i_r1(cur.r1),
        .i_payload(cur.payload), .i_block(cur.block), .i_blk_start(blk_start),
        .o_done(done), .o_errors(errors)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // CRC7 over start, index and argument, x^7 + x^3 + 1
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = c[6] ^ bits[i];
            c  = {c[5:3], c[2] ^ fb, c[1:0], fb};
        end
        return c;
    endfunction

    task automatic run_test(input test_t t);
        logic [6:0]  crc;
        logic [47:0] frame;
        crc = crc7({2'b01, t.index, t.arg});
        if (t.bad_crc) crc = crc ^ 7'h01;   // One flipped CRC bit
        frame = {2'b01, t.index, t.arg, crc, 1'b1};
        for (int i = 47; i >= 0; i--) begin
            @(negedge i_clk);
            i_mosi = frame[i];
            start  = (i == 47);
        end
        @(negedge i_clk);
        i_mosi = 1'b1;                      // FF bytes from here on
        while (!done) begin
            @(negedge i_clk);
        end
    endtask

    initial begin
        i_nrst    = 1'b0;
        i_cs      = 1'b1;
        i_mosi    = 1'b1;
        start     = 1'b0;
        cur       = '0;
        blk_start = 0;
        test_no   = 0;
        // name, index, argument, bad CRC, kind, r1, payload, block
        tests[0]  = '{"go_idle",       6'd0,  32'h0000_0000, 1'b0, K_R1, 8'h01, 32'h0, 1'b0};
        tests[1]  = '{"app_cmd",       6'd55, 32'h0000_0000, 1'b0, K_R1, 8'h01, 32'h0, 1'b0};
        tests[2]  = '{"op_cond_busy",  6'd41, 32'h40FF_8000, 1'b0, K_R1, 8'h01, 32'h0, 1'b0};
        tests[3]  = '{"unsupported",   6'd13, 32'h0000_0000, 1'b0, K_R1, 8'h05, 32'h0, 1'b0};
        tests[4]  = '{"if_cond",       6'd8,  32'h0000_01AA, 1'b0, K_R7, 8'h01, 32'h1AA, 1'b0};
        tests[5]  = '{"read_idle",     6'd17, 32'h0000_0002, 1'b0, K_R1, 8'h05, 32'h0, 1'b0};
        tests[6]  = '{"app_cmd_again", 6'd55, 32'h0000_0000, 1'b0, K_R1, 8'h01, 32'h0, 1'b0};
        tests[7]  = '{"op_cond_ready", 6'd41, 32'h40FF_8000, 1'b0, K_R1, 8'h00, 32'h0, 1'b0};
        tests[8]  = '{"read_ocr",      6'd58, 32'h0000_0000, 1'b0, K_R3, 8'h00,
                      32'hC0FF_8000, 1'b0};
        tests[9]  = '{"bad_crc",       6'd58, 32'h0000_0000, 1'b1, K_R1, 8'h08, 32'h0, 1'b0};
        tests[10] = '{"read_block_2",  6'd17, 32'h0000_0002, 1'b0, K_R1, 8'h00, 32'h0, 1'b1};
        tests[11] = '{"read_block_5",  6'd17, 32'h0000_0005, 1'b0, K_R1, 8'h00, 32'h0, 1'b1};
        tests[12] = '{"go_idle_again", 6'd0,  32'h0000_0000, 1'b0, K_R1, 8'h01, 32'h0, 1'b0};

        repeat (4) @(negedge i_clk);
        i_nrst = 1'b1;
        repeat (8) @(negedge i_clk);        // Host idle clocks
        i_cs = 1'b0;
        for (int n = 0; n < N_TESTS; n++) begin
            test_no   = n;
            cur       = tests[n];
            // Block start in bytes, wrapped to the memory size
            blk_start = int'((64'(tests[n].arg) * P_BLOCK_BYTES) % P_MEM_BYTES);
            run_test(tests[n]);
        end
        @(negedge i_clk);
        i_cs = 1'b1;
        repeat (2) @(negedge i_clk);

        $display("Tests run: %0d, errors: %0d", N_TESTS, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, test %0d never finished", cycles, test_no);
        $display("Tests run: %0d, errors: %0d", test_no, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sdcard_mem.hex
// One column: card data byte in hex, address 0 first, byte n = (3n + 1) mod 256
01
04
07
0A
0D
10
13
16
19
1C
1F
22
25
28
2B
2E
31
34
37
3A
3D
40
43
46
49
4C
4F
52
55
58
5B
5E
61
64
67
6A
6D
70
73
76
79
7C
7F
82
85
88
8B
8E
91
94
97
9A
9D
A0
A3
A6
A9
AC
AF
B2
B5
B8
BB
BE

//--- filelist.f
sdcard_pkg.sv
sdcard_crc16.sv
sdcard_mem.sv
sdcard_cmd_rx.sv
sdcard_resp_tx.sv
sdcard_ctrl.sv
sdcard_spi_top.sv
tb_sdcard_checker.sv
tb_sdcard.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Wno-fatal \
    -f filelist.f --top-module tb_sdcard -o tb_sdcard

out=$(./obj_dir/tb_sdcard)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
